// File: src.f
src/wb_pkg.sv
src/wb_master.sv
src/wb_decoder.sv
src/data_ram.sv
src/device_regs.sv
src/wb_subsystem_top.sv
tb/wb_master_properties.sv
tb/tb_wb_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -f src.f --top-module tb_wb_subsystem \
    -Mdir obj_dir -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "all tests passed" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: tb/tb_wb_subsystem.sv
// testbench for the bus subsystem, runs a command table against a reference model and reports
`timescale 1ns/1ps

module tb_wb_subsystem;

    import wb_pkg::*;

    localparam logic [1:0]  K_WR          = 2'd0;
    localparam logic [1:0]  K_RD          = 2'd1;
    localparam logic [1:0]  K_WR_BUSY_WR  = 2'd2;   // write, second write while busy
    localparam logic [1:0]  K_WR_BUSY_RD  = 2'd3;   // write, read while busy
    localparam logic [31:0] ID_WORD       = 32'hd0e5_1d03;
    localparam int          WAIT_LIMIT    = 20;
    localparam int          READ_LATENCY  = 3;
    localparam int          TAIL_CYCLES   = 4;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
    } entry_t;

    logic        clk;
    logic        rst;
    logic [31:0] cmd_addr;
    cmd_word_t   cmd_word;
    logic        cmd_busy;
    logic [31:0] cmd_rdata;
    logic        cmd_rdata_valid;

    entry_t      table_q [$];
    logic [31:0] mem_model [256];
    logic [31:0] dev_model [4][4];   // row 3 unused, identity unit
    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    int          test_no;

    wb_subsystem_top dut_i (
        .clk_i             (clk),
        .rst_i             (rst),
        .cmd_addr_i        (cmd_addr),
        .cmd_word_i        (cmd_word),
        .cmd_busy_o        (cmd_busy),
        .cmd_rdata_o       (cmd_rdata),
        .cmd_rdata_valid_o (cmd_rdata_valid)
    );

    bind wb_master wb_master_properties u_props (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (bus_o),
        .rdata_valid_i (cmd_rdata_valid_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] mem_addr(input int idx);
        logic [31:0] a;
        a = 32'b0;
        a[9:2] = idx[7:0];
        return a;
    endfunction

    function automatic logic [31:0] dev_addr(input int unit, input int r);
        logic [31:0] a;
        a = 32'b0;
        a[29] = 1'b1;   // device region
        a[17:16] = unit[1:0];
        a[3:2] = r[1:0];
        return a;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        if (!a[29]) begin
            return mem_model[a[9:2]];
        end
        if (a[17:16] == 2'd3) begin
            return ID_WORD;
        end
        return dev_model[a[17:16]][a[3:2]];
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            K_WR:         return "write";
            K_RD:         return "read";
            K_WR_BUSY_WR: return "write+busy write";
            default:      return "write+busy read";
        endcase
    endfunction

    // writes update the model as the table is built
    task automatic add_write(input logic [1:0] kind, input logic [31:0] a, input logic [31:0] d);
        entry_t e;
        e.kind  = kind;
        e.addr  = a;
        e.wdata = d;
        e.exp   = 32'b0;
        table_q.push_back(e);
        if (!a[29]) begin
            mem_model[a[9:2]] = d;
        end else if (a[17:16] != 2'd3) begin
            dev_model[a[17:16]][a[3:2]] = d;   // identity unit ignores writes
        end
    endtask

    task automatic add_read(input logic [31:0] a);
        entry_t e;
        e.kind  = K_RD;
        e.addr  = a;
        e.wdata = 32'b0;
        e.exp   = model_read(a);
        table_q.push_back(e);
    endtask

    task automatic build_table();
        for (int u = 0; u < 4; u++) begin
            for (int r = 0; r < 4; r++) begin
                dev_model[u][r] = 32'b0;
            end
        end
        // memory, last write wins at index 5
        add_write(K_WR, mem_addr(0), $random(seed));
        add_write(K_WR, mem_addr(5), $random(seed));
        add_write(K_WR, mem_addr(8'h80), $random(seed));
        add_write(K_WR, mem_addr(8'hff), $random(seed));
        add_read(mem_addr(0));
        add_read(mem_addr(5));
        add_read(mem_addr(8'h80));
        add_read(mem_addr(8'hff));
        add_write(K_WR, mem_addr(5), $random(seed));
        add_read(mem_addr(5));
        // scratch units, same register index in each
        add_read(dev_addr(1, 0));
        add_write(K_WR, dev_addr(0, 1), $random(seed));
        add_write(K_WR, dev_addr(1, 1), $random(seed));
        add_write(K_WR, dev_addr(2, 1), $random(seed));
        add_write(K_WR, dev_addr(2, 3), $random(seed));
        add_read(dev_addr(0, 1));
        add_read(dev_addr(1, 1));
        add_read(dev_addr(2, 1));
        add_read(dev_addr(2, 3));
        // identity unit
        add_read(dev_addr(3, 0));
        add_write(K_WR, dev_addr(3, 2), $random(seed));
        add_read(dev_addr(3, 2));
        add_read(dev_addr(3, 0));
        // commands presented while busy
        add_write(K_WR_BUSY_WR, mem_addr(8'h40), $random(seed));
        add_read(mem_addr(8'h40));
        add_write(K_WR_BUSY_RD, mem_addr(8'h41), $random(seed));
        add_read(mem_addr(8'h41));
    endtask

    task automatic drive_command(input logic rd, input logic wr, input logic [31:0] a,
                                 input logic [31:0] d);
        cmd_addr        = a;
        cmd_word.rd_req = rd;
        cmd_word.wr_req = wr;
        cmd_word.wdata  = d;
    endtask

    task automatic expect_true(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("FAIL %0t: test %0d %s", $time, test_no, what);
            errors++;
        end
    endtask

    // starts one posedge plus 1 ns, leaves at the same phase
    task automatic run_command(input entry_t e, output logic [31:0] rdata, output int valid_cycle,
                               output int pulses, output int idle_cycle, output bit timed_out);
        int cycles;
        int waited;
        rdata       = 32'b0;
        valid_cycle = 0;
        pulses      = 0;
        idle_cycle  = 0;
        timed_out   = 1'b0;
        cycles      = 0;
        drive_command(e.kind == K_RD, e.kind != K_RD, e.addr, e.wdata);
        while (idle_cycle == 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles == 1 && e.kind == K_WR_BUSY_WR) begin
                drive_command(1'b0, 1'b1, e.addr, ~e.wdata);
            end else if (cycles == 1 && e.kind == K_WR_BUSY_RD) begin
                drive_command(1'b1, 1'b0, e.addr, 32'b0);
            end else begin
                drive_command(1'b0, 1'b0, 32'b0, 32'b0);
            end
            if (cmd_rdata_valid) begin
                pulses++;
                valid_cycle = cycles;
                rdata = cmd_rdata;
            end
            if (!cmd_busy) idle_cycle = cycles;
        end
        drive_command(1'b0, 1'b0, 32'b0, 32'b0);
        if (idle_cycle == 0) begin
            $display("timeout: test %0d, busy did not fall within %0d cycles", test_no, WAIT_LIMIT);
            timed_out = 1'b1;
            return;
        end
        waited = 0;
        while (e.kind == K_RD && valid_cycle == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            waited++;
            if (cmd_rdata_valid) begin
                pulses++;
                valid_cycle = cycles;
                rdata = cmd_rdata;
            end
        end
        if (e.kind == K_RD && valid_cycle == 0) begin
            $display("timeout: test %0d, read data never became valid", test_no);
            timed_out = 1'b1;
            return;
        end
        // watch for stray pulses
        repeat (TAIL_CYCLES) begin
            @(posedge clk);
            #1;
            if (cmd_rdata_valid) pulses++;
        end
    endtask

    task automatic report_and_finish();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial begin
        entry_t      e;
        logic [31:0] rdata;
        int          valid_cycle;
        int          pulses;
        int          idle_cycle;
        bit          timed_out;
        int          errors_before;
        clk      = 1'b0;
        rst      = 1'b0;
        cmd_addr = 32'b0;
        cmd_word = '0;
        seed     = 32'hf6b6;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        test_no  = 0;
        build_table();

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        expect_true(!cmd_busy, "busy high after reset");
        expect_true(!cmd_rdata_valid, "read data valid high after reset");
        $display("test 0 reset: %s", (errors == 0) ? "ok" : "mismatch");

        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            test_no = i + 1;
            errors_before = errors;
            run_command(e, rdata, valid_cycle, pulses, idle_cycle, timed_out);
            if (timed_out) begin
                errors++;
                $display("run stopped at test %0d after a timeout", test_no);
                break;
            end
            expect_true(idle_cycle <= READ_LATENCY,
                        $sformatf("busy fell at cycle %0d, expected by %0d", idle_cycle,
                                  READ_LATENCY));
            if (e.kind == K_RD) begin
                expect_true(pulses == 1, $sformatf("%0d valid pulses, expected 1", pulses));
                expect_true(valid_cycle == READ_LATENCY,
                            $sformatf("valid at cycle %0d, expected %0d", valid_cycle,
                                      READ_LATENCY));
                expect_true(rdata === e.exp,
                            $sformatf("addr %h read %h, expected %h", e.addr, rdata, e.exp));
            end else begin
                expect_true(pulses == 0, $sformatf("%0d valid pulses after a write", pulses));
            end
            tests++;
            $display("test %0d %s addr %h: %s", test_no, kind_name(e.kind), e.addr,
                     (errors == errors_before) ? "ok" : "mismatch");
        end
        report_and_finish();
    end

endmodule

// File: tb/wb_master_properties.sv
// bus protocol assertions for the master, attached to wb_master by a bind in the testbench
`timescale 1ns/1ps

module wb_master_properties (
    input  logic            clk_i,
    input  logic            rst_i,
    input  wb_pkg::wb_req_t req_i,
    input  logic            rdata_valid_i
);

    // strobe only inside a cycle
    stb_within_cyc: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        req_i.stb |-> req_i.cyc
    ) else $error("stb is high while cyc is low");

    // single beat
    stb_one_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        req_i.stb |=> !req_i.stb
    ) else $error("stb stayed high for more than one cycle");

    valid_is_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        rdata_valid_i |=> !rdata_valid_i
    ) else $error("read data valid stayed high for more than one cycle");

    // at most three samples of cyc in a row
    cyc_bounded: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        (req_i.cyc && $past(req_i.cyc) && $past(req_i.cyc, 2)) |=> !req_i.cyc
    ) else $error("cyc did not fall within 3 cycles");

endmodule

// File: src/wb_subsystem_top.sv
// top of the memory and device bus: processor command port in, master, decoder and two slaves
`timescale 1ns/1ps

module wb_subsystem_top (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic [31:0]       cmd_addr_i,
    input  wb_pkg::cmd_word_t cmd_word_i,
    output logic              cmd_busy_o,
    output logic [31:0]       cmd_rdata_o,
    output logic              cmd_rdata_valid_o
);

    import wb_pkg::*;

    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    wb_rsp_t ram_rsp;
    wb_rsp_t dev_rsp;
    logic    ram_stb;
    logic    dev_stb;

    wb_master u_master (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .cmd_addr_i        (cmd_addr_i),
        .cmd_word_i        (cmd_word_i),
        .cmd_busy_o        (cmd_busy_o),
        .cmd_rdata_o       (cmd_rdata_o),
        .cmd_rdata_valid_o (cmd_rdata_valid_o),
        .bus_o             (bus_req),
        .bus_i             (bus_rsp)
    );

    wb_decoder u_decoder (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (bus_req),
        .ram_stb_o (ram_stb),
        .dev_stb_o (dev_stb),
        .ram_rsp_i (ram_rsp),
        .dev_rsp_i (dev_rsp),
        .rsp_o     (bus_rsp)
    );

    data_ram u_ram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (bus_req),
        .stb_i (ram_stb),
        .rsp_o (ram_rsp)
    );

    device_regs u_dev (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (bus_req),
        .stb_i (dev_stb),
        .rsp_o (dev_rsp)
    );

endmodule

// File: src/device_regs.sv
// device block: three scratch register units and a read-only identity unit, picked by sel
`timescale 1ns/1ps

module device_regs (
    input  logic            clk_i,
    input  logic            rst_i,

    input  wb_pkg::wb_req_t req_i,
    input  logic            stb_i,
    output wb_pkg::wb_rsp_t rsp_o
);

    import wb_pkg::*;

    logic [31:0] scratch_q [SCRATCH_UNITS][UNIT_REGS];
    logic [1:0]  unit;
    logic [1:0]  reg_idx;
    logic        id_hit;
    logic [31:0] rdata_q;
    logic        ack_q;

    // unit comes from sel, master already decoded it from the address
    assign unit    = req_i.sel;
    assign reg_idx = req_i.addr.dev.reg_idx;
    assign id_hit  = (unit == ID_UNIT);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int u = 0; u < SCRATCH_UNITS; u++) begin
                for (int r = 0; r < UNIT_REGS; r++) begin
                    scratch_q[u][r] <= 32'b0;
                end
            end
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i;
            if (stb_i && req_i.we && !id_hit) begin
                scratch_q[unit][reg_idx] <= req_i.wdata;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (stb_i) begin
            if (id_hit) begin
                rdata_q <= DEVICE_ID;   // writes to unit 3 dropped
            end else if (req_i.we) begin
                rdata_q <= req_i.wdata;
            end else begin
                rdata_q <= scratch_q[unit][reg_idx];
            end
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.ack   = ack_q;
    assign rsp_o.tag   = ^rdata_q;

endmodule

// File: src/data_ram.sv
// data memory slave: 256 words, one-cycle ack with the data parity as tag
`timescale 1ns/1ps

module data_ram (
    input  logic            clk_i,
    input  logic            rst_i,

    input  wb_pkg::wb_req_t req_i,
    input  logic            stb_i,
    output wb_pkg::wb_rsp_t rsp_o
);

    import wb_pkg::*;

    logic [31:0] mem_q [RAM_WORDS];
    logic [7:0]  idx;
    logic [31:0] rdata_q;
    logic        ack_q;

    assign idx = req_i.addr.mem.word_idx;

    always_ff @(posedge clk_i) begin
        if (stb_i) begin
            if (req_i.we) begin
                mem_q[idx] <= req_i.wdata;
                rdata_q    <= req_i.wdata;   // write echoes the word
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i;   // one beat after stb
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.ack   = ack_q;
    assign rsp_o.tag   = ^rdata_q;

endmodule

// File: src/wb_decoder.sv
// address decoder: steers the strobe to memory or devices and returns the chosen slave response
`timescale 1ns/1ps

module wb_decoder (
    input  logic            clk_i,
    input  logic            rst_i,

    input  wb_pkg::wb_req_t req_i,
    output logic            ram_stb_o,
    output logic            dev_stb_o,

    input  wb_pkg::wb_rsp_t ram_rsp_i,
    input  wb_pkg::wb_rsp_t dev_rsp_i,
    output wb_pkg::wb_rsp_t rsp_o
);

    import wb_pkg::*;

    logic hit_dev;
    logic strobe;
    logic dev_sel_q;   // slave picked for the running cycle

    assign hit_dev = (req_i.addr.mem.region == REGION_DEVICE);
    assign strobe  = req_i.cyc && req_i.stb;

    assign dev_stb_o = strobe && hit_dev;
    assign ram_stb_o = strobe && !hit_dev;

    // addr is cleared once stb drops, so hold the choice
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            dev_sel_q <= 1'b0;
        end else if (strobe) begin
            dev_sel_q <= hit_dev;
        end
    end

    always_comb begin
        if (dev_sel_q) begin
            rsp_o = dev_rsp_i;
        end else begin
            rsp_o = ram_rsp_i;
        end
        rsp_o.ack = rsp_o.ack && req_i.cyc;   // no ack outside a cycle
    end

endmodule

// File: src/wb_master.sv
// bus master: turns processor command words into single-beat bus cycles and checks the ack tag
`timescale 1ns/1ps

module wb_master (
    input  logic              clk_i,
    input  logic              rst_i,

    // processor side
    input  wb_pkg::bus_addr_u cmd_addr_i,
    input  wb_pkg::cmd_word_t cmd_word_i,
    output logic              cmd_busy_o,
    output logic [31:0]       cmd_rdata_o,
    output logic              cmd_rdata_valid_o,

    // bus side
    output wb_pkg::wb_req_t   bus_o,
    input  wb_pkg::wb_rsp_t   bus_i
);

    import wb_pkg::*;

    wb_req_t     req_q;
    wb_req_t     req_d;
    logic        rd_q;     // current cycle is a read
    logic        rd_d;
    logic        valid_q;
    logic        valid_d;
    logic [31:0] rdata_q;
    logic        ack_ok;
    logic        take_rdata;

    // ack only counts when the tag agrees with the returned data
    assign ack_ok = bus_i.ack && (bus_i.tag == ^bus_i.rdata);

    always_comb begin
        req_d      = req_q;
        rd_d       = rd_q;
        valid_d    = 1'b0;
        take_rdata = 1'b0;

        if (!req_q.cyc) begin
            if (cmd_word_i.rd_req || cmd_word_i.wr_req) begin
                req_d.addr  = cmd_addr_i;
                req_d.cyc   = 1'b1;
                req_d.stb   = 1'b1;
                req_d.we    = !cmd_word_i.rd_req;   // read wins
                req_d.wdata = cmd_word_i.rd_req ? 32'b0 : cmd_word_i.wdata;
                req_d.tag   = ^req_d.wdata;
                if (cmd_addr_i.dev.region == REGION_DEVICE) begin
                    req_d.sel = cmd_addr_i.dev.unit;
                end else begin
                    req_d.sel = SEL_MEMORY;
                end
                rd_d = cmd_word_i.rd_req;
            end
        end else if (req_q.stb) begin
            // single beat, strobe only for one cycle
            req_d.stb   = 1'b0;
            req_d.addr  = '0;
            req_d.wdata = 32'b0;
            req_d.we    = 1'b0;
            req_d.tag   = 1'b0;
        end else if (ack_ok) begin
            req_d.cyc  = 1'b0;
            req_d.sel  = SEL_MEMORY;
            rd_d       = 1'b0;
            valid_d    = rd_q;
            take_rdata = rd_q;
        end
        // bad tag keeps cyc up and waits
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            req_q.addr  <= '0;
            req_q.wdata <= 32'b0;
            req_q.we    <= 1'b0;
            req_q.cyc   <= 1'b0;
            req_q.stb   <= 1'b0;
            req_q.sel   <= SEL_MEMORY;
            req_q.tag   <= 1'b0;
            rd_q        <= 1'b0;
            valid_q     <= 1'b0;
        end else begin
            req_q   <= req_d;
            rd_q    <= rd_d;
            valid_q <= valid_d;
        end
    end

    // read data holds until the next read completes
    always_ff @(posedge clk_i) begin
        if (take_rdata) begin
            rdata_q <= bus_i.rdata;
        end
    end

    assign bus_o             = req_q;
    assign cmd_busy_o        = req_q.cyc;
    assign cmd_rdata_o       = rdata_q;
    assign cmd_rdata_valid_o = valid_q;

endmodule

// File: src/wb_pkg.sv
// shared bus types and sizes for the processor memory/device bus, imported by every RTL block
package wb_pkg;

    localparam logic        REGION_DEVICE = 1'b1;      // region bit value for device space
    localparam logic [1:0]  SEL_MEMORY    = 2'b11;     // sel for memory cycles and idle
    localparam int          RAM_WORDS     = 256;
    localparam logic [31:0] DEVICE_ID     = 32'hd0e5_1d03;
    localparam logic [1:0]  ID_UNIT       = 2'd3;      // read-only identity unit
    localparam int          SCRATCH_UNITS = 3;
    localparam int          UNIT_REGS     = 4;

    // processor command, bit 33 write, bit 32 read
    typedef struct packed {
        logic        wr_req;
        logic        rd_req;
        logic [31:0] wdata;
    } cmd_word_t;

    // one address word, seen either as a memory word or a device register
    typedef union packed {
        struct packed {
            logic [1:0]  rsvd_hi;
            logic        region;
            logic [18:0] unused;
            logic [7:0]  word_idx;
            logic [1:0]  byte_off;
        } mem;
        struct packed {
            logic [1:0]  rsvd_hi;
            logic        region;
            logic [10:0] unused_hi;
            logic [1:0]  unit;
            logic [11:0] unused_lo;
            logic [1:0]  reg_idx;
            logic [1:0]  byte_off;
        } dev;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u   addr;
        logic [31:0] wdata;
        logic        we;
        logic        cyc;
        logic        stb;
        logic [1:0]  sel;
        logic        tag;   // even parity of wdata
    } wb_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
        logic        tag;   // even parity of rdata
    } wb_rsp_t;

endpackage
